// ==== verilog/vec_pkg.sv ====
/* Shared types and constants of the vector coprocessor.
   Modules pull these in with a wildcard import in the body and scoped names in port lists. */
package vec_pkg;

  ////////////////////////////////////////////////////////////
  // Element and register file geometry
  ////////////////////////////////////////////////////////////

  // One vector element is one 32-bit word
  localparam int unsigned ElemWidth = 32;

  typedef logic [ElemWidth-1:0] elen_t;

  // Architectural vector registers v0 to v7
  localparam int unsigned NrVRegs = 8;

  typedef logic [$clog2(NrVRegs)-1:0] vreg_idx_t;

  // Upper bound on the lane count accepted by the top level
  localparam int unsigned MaxNrLanes = 8;

  ////////////////////////////////////////////////////////////
  // Operations
  ////////////////////////////////////////////////////////////

  // Write operations first, then the two scalar-result operations
  typedef enum logic [2:0] {
    // vd[i] = scalar
    VMV_V_X  = 3'd0,
    // vd[i] = vs2[i] + vs1[i]
    VADD     = 3'd1,
    // vd[i] = vs2[i] - vs1[i]
    VSUB     = 3'd2,
    // vd[i] = vs2[i] & vs1[i]
    VAND     = 3'd3,
    // vd[i] = vs2[i] ^ vs1[i]
    VXOR     = 3'd4,
    // Sum of all elements of vs2, modulo 2^32
    VREDSUM  = 3'd5,
    // Number of positions where vs1 and vs2 agree
    VCPOP_EQ = 3'd6
  } vop_e;

endpackage : vec_pkg

// ==== verilog/vec_dispatcher.sv ====
/* Front end of the coprocessor: accepts one instruction at a time from the scalar core,
   strobes it to the lanes and reduction unit, and returns the scalar result. */
`timescale 1ns/1ps

module vec_dispatcher #(
  parameter int unsigned ElemsPerLane = 4
) (
  input  logic               clk_i,
  input  logic               reset_i,
  // Request from the scalar core
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  input  vec_pkg::vop_e      acc_op_i,
  input  vec_pkg::vreg_idx_t acc_vd_i,
  input  vec_pkg::vreg_idx_t acc_vs1_i,
  input  vec_pkg::vreg_idx_t acc_vs2_i,
  input  vec_pkg::elen_t     acc_scalar_i,
  // Response to the scalar core
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i,
  output vec_pkg::elen_t     acc_resp_result_o,
  // Completions from the processing elements
  input  logic               lane_done_i,
  input  logic               red_done_i,
  input  vec_pkg::elen_t     red_result_i,
  // Broadcast to the processing elements
  output logic               pe_req_valid_o,
  output vec_pkg::vop_e      pe_op_o,
  output vec_pkg::vreg_idx_t pe_vd_o,
  output vec_pkg::vreg_idx_t pe_vs1_o,
  output vec_pkg::vreg_idx_t pe_vs2_o,
  output vec_pkg::elen_t     pe_scalar_o
);
  import vec_pkg::*;

  typedef enum logic [1:0] {IDLE, ISSUE, WAIT_DONE, RESPOND} state_e;

  state_e    state_q;
  logic      lane_seen_q;
  logic      red_seen_q;
  logic      req_fire;
  vop_e      op_q;
  vreg_idx_t vd_q;
  vreg_idx_t vs1_q;
  vreg_idx_t vs2_q;
  elen_t     scalar_q;
  elen_t     result_q;

  // Only one instruction in flight, so ready is just the idle state
  assign acc_req_ready_o  = (state_q == IDLE);
  assign req_fire         = acc_req_valid_i && acc_req_ready_o;
  assign pe_req_valid_o   = (state_q == ISSUE);
  assign acc_resp_valid_o = (state_q == RESPOND);

  assign pe_op_o           = op_q;
  assign pe_vd_o           = vd_q;
  assign pe_vs1_o          = vs1_q;
  assign pe_vs2_o          = vs2_q;
  assign pe_scalar_o       = scalar_q;
  assign acc_resp_result_o = result_q;

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= IDLE;
      lane_seen_q <= 1'b0;
      red_seen_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (req_fire) begin
            state_q     <= ISSUE;
            lane_seen_q <= 1'b0;
            red_seen_q  <= 1'b0;
          end
        end
        // Strobe lasts a single cycle
        ISSUE: state_q <= WAIT_DONE;
        WAIT_DONE: begin
          // Sticky, the two pulses come in different cycles
          if (lane_done_i) lane_seen_q <= 1'b1;
          if (red_done_i) red_seen_q <= 1'b1;
          if (lane_seen_q && red_seen_q) state_q <= RESPOND;
        end
        RESPOND: begin
          if (acc_resp_ready_i) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Instruction and result payload
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      op_q     <= acc_op_i;
      vd_q     <= acc_vd_i;
      vs1_q    <= acc_vs1_i;
      vs2_q    <= acc_vs2_i;
      scalar_q <= acc_scalar_i;
    end
    if (red_done_i) result_q <= red_result_i;
  end

  // Completion hinges on the lane pulse of the final slot
  if (ElemsPerLane == 0)
    $error("[vec_dispatcher] Each lane needs at least one element slot.");

endmodule : vec_dispatcher

// ==== verilog/vec_lane.sv ====
/* One vector lane: its slice of every vector register, an element-wise ALU,
   and the per-slot operand stream toward the reduction unit. */
`timescale 1ns/1ps

module vec_lane #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 4
) (
  input  logic               clk_i,
  input  logic               reset_i,
  // Instruction broadcast
  input  logic               pe_req_valid_i,
  input  vec_pkg::vop_e      pe_op_i,
  input  vec_pkg::vreg_idx_t pe_vd_i,
  input  vec_pkg::vreg_idx_t pe_vs1_i,
  input  vec_pkg::vreg_idx_t pe_vs2_i,
  input  vec_pkg::elen_t     pe_scalar_i,
  // Operand stream and completion
  output logic               operand_valid_o,
  output vec_pkg::elen_t     operand_a_o,
  output vec_pkg::elen_t     operand_b_o,
  output logic               lane_done_o
);
  import vec_pkg::*;

  // Elements of one vector register, spread round-robin over the lanes
  localparam int unsigned VecElems  = NrLanes * ElemsPerLane;
  localparam int unsigned NrSlots   = VecElems / NrLanes;
  localparam int unsigned SlotWidth = (NrSlots > 1) ? $clog2(NrSlots) : 1;
  localparam logic [SlotWidth-1:0] LastSlot = SlotWidth'(NrSlots - 1);

  elen_t                vrf_q [NrVRegs][NrSlots];
  logic                 active_q;
  logic [SlotWidth-1:0] slot_q;
  vop_e                 op_q;
  vreg_idx_t            vd_q;
  vreg_idx_t            vs1_q;
  vreg_idx_t            vs2_q;
  elen_t                scalar_q;
  elen_t                vs1_elem;
  elen_t                vs2_elem;
  elen_t                alu_res;
  logic                 write_en;

  // Both source slots are read every cycle of the walk
  assign vs1_elem = vrf_q[vs1_q][slot_q];
  assign vs2_elem = vrf_q[vs2_q][slot_q];

  assign operand_valid_o = active_q;
  assign operand_a_o     = vs1_elem;
  assign operand_b_o     = vs2_elem;
  assign lane_done_o     = active_q && (slot_q == LastSlot);

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (op_q)
      VMV_V_X: alu_res = scalar_q;
      VADD:    alu_res = vs2_elem + vs1_elem;
      VSUB:    alu_res = vs2_elem - vs1_elem;
      VAND:    alu_res = vs2_elem & vs1_elem;
      VXOR:    alu_res = vs2_elem ^ vs1_elem;
      default: alu_res = '0;
    endcase
  end

  // Reductions only read
  assign write_en = active_q && (op_q inside {VMV_V_X, VADD, VSUB, VAND, VXOR});

  // Slot walk and register file
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q <= 1'b0;
      slot_q   <= '0;
      for (int r = 0; r < NrVRegs; r++) begin
        for (int s = 0; s < NrSlots; s++) begin
          vrf_q[r][s] <= '0;
        end
      end
    end else begin
      if (pe_req_valid_i) begin
        active_q <= 1'b1;
        slot_q   <= '0;
      end else if (active_q) begin
        if (slot_q == LastSlot) begin
          active_q <= 1'b0;
          slot_q   <= '0;
        end else begin
          slot_q <= slot_q + SlotWidth'(1);
        end
      end
      if (write_en) vrf_q[vd_q][slot_q] <= alu_res;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pe_req_valid_i) begin
      op_q     <= pe_op_i;
      vd_q     <= pe_vd_i;
      vs1_q    <= pe_vs1_i;
      vs2_q    <= pe_vs2_i;
      scalar_q <= pe_scalar_i;
    end
  end

endmodule : vec_lane

// ==== verilog/vec_reduction.sv ====
/* Reduction unit: folds the operand streams of all lanes into a sum of vs2
   or a count of equal vs1/vs2 positions, and reports it once the stream ends. */
`timescale 1ns/1ps

module vec_reduction #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           pe_req_valid_i,
  input  vec_pkg::vop_e                  pe_op_i,
  // One operand pair per lane and cycle
  input  logic           [NrLanes-1:0]   operand_valid_i,
  input  vec_pkg::elen_t [NrLanes-1:0]   operand_a_i,
  input  vec_pkg::elen_t [NrLanes-1:0]   operand_b_i,
  output logic                           red_done_o,
  output vec_pkg::elen_t                 red_result_o
);
  import vec_pkg::*;

  logic  is_sum_q;
  logic  is_cpop_q;
  logic  in_stream_q;
  logic  any_valid;
  elen_t acc_q;
  elen_t lane_sum;
  elen_t lane_matches;
  elen_t step;

  assign any_valid = |operand_valid_i;

  // Contribution of one slot across all lanes
  always_comb begin
    lane_sum     = '0;
    lane_matches = '0;
    for (int l = 0; l < NrLanes; l++) begin
      if (operand_valid_i[l]) begin
        lane_sum = lane_sum + operand_b_i[l];
        if (operand_a_i[l] == operand_b_i[l]) lane_matches = lane_matches + elen_t'(1);
      end
    end
  end

  // Write operations fold nothing, so their result stays zero
  assign step = is_sum_q ? lane_sum : (is_cpop_q ? lane_matches : '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      is_sum_q    <= 1'b0;
      is_cpop_q   <= 1'b0;
      in_stream_q <= 1'b0;
    end else begin
      if (pe_req_valid_i) begin
        is_sum_q  <= (pe_op_i == VREDSUM);
        is_cpop_q <= (pe_op_i == VCPOP_EQ);
      end
      in_stream_q <= any_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pe_req_valid_i) acc_q <= '0;
    else if (any_valid) acc_q <= acc_q + step;
  end

  // Falling edge of the stream, one cycle after the last slot
  assign red_done_o   = in_stream_q && !any_valid;
  assign red_result_o = acc_q;

endmodule : vec_reduction

// ==== verilog/vec_top.sv ====
/* Top level of the vector coprocessor: dispatcher, NrLanes lanes and the reduction unit.
   Set NrLanes and ElemsPerLane here; they are passed down to every block. */
`timescale 1ns/1ps

module vec_top #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 4
) (
  input  logic               clk_i,
  input  logic               reset_i,
  // Request from the scalar core
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  input  vec_pkg::vop_e      acc_op_i,
  input  vec_pkg::vreg_idx_t acc_vd_i,
  input  vec_pkg::vreg_idx_t acc_vs1_i,
  input  vec_pkg::vreg_idx_t acc_vs2_i,
  input  vec_pkg::elen_t     acc_scalar_i,
  // Response to the scalar core
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i,
  output vec_pkg::elen_t     acc_resp_result_o
);
  import vec_pkg::*;

  // Instruction broadcast
  logic      pe_req_valid;
  vop_e      pe_op;
  vreg_idx_t pe_vd;
  vreg_idx_t pe_vs1;
  vreg_idx_t pe_vs2;
  elen_t     pe_scalar;
  // Lane outputs
  logic  [NrLanes-1:0] operand_valid;
  elen_t [NrLanes-1:0] operand_a;
  elen_t [NrLanes-1:0] operand_b;
  logic  [NrLanes-1:0] lane_done;
  // Reduction outputs
  logic  red_done;
  elen_t red_result;

  vec_dispatcher #(
    .ElemsPerLane(ElemsPerLane)
  ) i_dispatcher (
    .clk_i            (clk_i            ),
    .reset_i          (reset_i          ),
    .acc_req_valid_i  (acc_req_valid_i  ),
    .acc_req_ready_o  (acc_req_ready_o  ),
    .acc_op_i         (acc_op_i         ),
    .acc_vd_i         (acc_vd_i         ),
    .acc_vs1_i        (acc_vs1_i        ),
    .acc_vs2_i        (acc_vs2_i        ),
    .acc_scalar_i     (acc_scalar_i     ),
    .acc_resp_valid_o (acc_resp_valid_o ),
    .acc_resp_ready_i (acc_resp_ready_i ),
    .acc_resp_result_o(acc_resp_result_o),
    // Lanes run in lockstep, lane 0 speaks for all of them
    .lane_done_i      (lane_done[0]     ),
    .red_done_i       (red_done         ),
    .red_result_i     (red_result       ),
    .pe_req_valid_o   (pe_req_valid     ),
    .pe_op_o          (pe_op            ),
    .pe_vd_o          (pe_vd            ),
    .pe_vs1_o         (pe_vs1           ),
    .pe_vs2_o         (pe_vs2           ),
    .pe_scalar_o      (pe_scalar        )
  );

  ////////////////////////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////////////////////////

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .NrLanes     (NrLanes     ),
      .ElemsPerLane(ElemsPerLane)
    ) i_lane (
      .clk_i          (clk_i           ),
      .reset_i        (reset_i         ),
      .pe_req_valid_i (pe_req_valid    ),
      .pe_op_i        (pe_op           ),
      .pe_vd_i        (pe_vd           ),
      .pe_vs1_i       (pe_vs1          ),
      .pe_vs2_i       (pe_vs2          ),
      .pe_scalar_i    (pe_scalar       ),
      .operand_valid_o(operand_valid[l]),
      .operand_a_o    (operand_a[l]    ),
      .operand_b_o    (operand_b[l]    ),
      .lane_done_o    (lane_done[l]    )
    );
  end : gen_lanes

  vec_reduction #(
    .NrLanes(NrLanes)
  ) i_reduction (
    .clk_i          (clk_i        ),
    .reset_i        (reset_i      ),
    .pe_req_valid_i (pe_req_valid ),
    .pe_op_i        (pe_op        ),
    .operand_valid_i(operand_valid),
    .operand_a_i    (operand_a    ),
    .operand_b_i    (operand_b    ),
    .red_done_o     (red_done     ),
    .red_result_o   (red_result   )
  );

  // Parameter legality
  if (NrLanes == 0)
    $error("[vec_top] At least one lane is required.");

  if (NrLanes != 2**$clog2(NrLanes))
    $error("[vec_top] The number of lanes must be a power of two.");

  if (NrLanes > MaxNrLanes)
    $error("[vec_top] At most MaxNrLanes lanes are supported.");

endmodule : vec_top

// ==== dv/vec_tb_asserts.sv ====
/* Handshake checks for the dispatcher, bound into every vec_dispatcher instance.
   Each failure bumps error_count, which the testbench polls every cycle. */
`timescale 1ns/1ps

module vec_tb_asserts (
  input logic           clk_i,
  input logic           reset_i,
  input logic           pe_req_valid_i,
  input logic           req_ready_i,
  input logic           resp_valid_i,
  input logic           resp_ready_i,
  input vec_pkg::elen_t resp_result_i
);
  import vec_pkg::*;

  int unsigned error_count = 0;

  // Issue strobe is a single-cycle pulse
  pe_strobe_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    pe_req_valid_i |=> !pe_req_valid_i)
    else begin
      error_count++;
      $error("pe_req_valid stayed high for more than one cycle");
    end

  // Response held with an unchanged result until taken
  resp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_result_i))
    else begin
      error_count++;
      $error("Response dropped or changed before acc_resp_ready_i");
    end

  resp_blocks_req: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_valid_i |-> !req_ready_i)
    else begin
      error_count++;
      $error("acc_req_ready_o high while a response is pending");
    end

endmodule : vec_tb_asserts

bind vec_dispatcher vec_tb_asserts i_asserts (
  .clk_i         (clk_i            ),
  .reset_i       (reset_i          ),
  .pe_req_valid_i(pe_req_valid_o   ),
  .req_ready_i   (acc_req_ready_o  ),
  .resp_valid_i  (acc_resp_valid_o ),
  .resp_ready_i  (acc_resp_ready_i ),
  .resp_result_i (acc_resp_result_o)
);

// ==== dv/vec_tb.sv ====
/* Table-driven testbench for vec_top: a reference model of the register file predicts
   every scalar result, and responses are checked for value, latency and back-pressure. */
`timescale 1ns/1ps

module vec_tb;
  import vec_pkg::*;

  localparam int NrLanes        = 4;
  localparam int ElemsPerLane   = 4;
  localparam int VecElems       = NrLanes * ElemsPerLane;
  localparam int NumTests       = 18;
  localparam int WatchdogCycles = NumTests * (ElemsPerLane + 10) + 50;

  typedef struct {
    vop_e      op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elen_t     scalar;
    // Cycles with acc_resp_ready_i held low
    int        hold;
  } entry_t;

  logic      clk_i;
  logic      reset_i;
  logic      acc_req_valid_i;
  logic      acc_req_ready_o;
  vop_e      acc_op_i;
  vreg_idx_t acc_vd_i;
  vreg_idx_t acc_vs1_i;
  vreg_idx_t acc_vs2_i;
  elen_t     acc_scalar_i;
  logic      acc_resp_valid_o;
  logic      acc_resp_ready_i;
  elen_t     acc_resp_result_o;

  entry_t    stim [NumTests];
  elen_t     model_vrf [NrVRegs][VecElems];
  int        req_count = 0;
  int        resp_count = 0;
  int        seed;

  vec_top #(
    .NrLanes     (NrLanes     ),
    .ElemsPerLane(ElemsPerLane)
  ) vec_top_i (
    .clk_i            (clk_i            ),
    .reset_i          (reset_i          ),
    .acc_req_valid_i  (acc_req_valid_i  ),
    .acc_req_ready_o  (acc_req_ready_o  ),
    .acc_op_i         (acc_op_i         ),
    .acc_vd_i         (acc_vd_i         ),
    .acc_vs1_i        (acc_vs1_i        ),
    .acc_vs2_i        (acc_vs2_i        ),
    .acc_scalar_i     (acc_scalar_i     ),
    .acc_resp_valid_o (acc_resp_valid_o ),
    .acc_resp_ready_i (acc_resp_ready_i ),
    .acc_resp_result_o(acc_resp_result_o)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // Handshake counters, sampled before the edge updates the DUT
  always @(posedge clk_i) begin
    if (!reset_i && acc_req_valid_i && acc_req_ready_o) req_count++;
    if (!reset_i && acc_resp_valid_o && acc_resp_ready_i) resp_count++;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Timeout: the DUT did not finish all %0d table entries in time", NumTests);
    $display("*** FAILED ***");
    $fatal(1, "Watchdog expired");
  end

  // Dispatcher protocol assertions end the run at their first failure
  always @(negedge clk_i) begin
    if (vec_top_i.i_dispatcher.i_asserts.error_count != 0) begin
      $display("Dispatcher protocol assertion failed before %0t ns", $time);
      $display("*** FAILED ***");
      $fatal(1, "Protocol check failed");
    end
  end

  task automatic stop_with_error(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("*** FAILED ***");
    $fatal(1, "Check failed");
  endtask

  task automatic set_entry(input int idx, input vop_e op, input int vd, input int vs1,
                           input int vs2, input elen_t scalar, input int hold);
    stim[idx].op     = op;
    stim[idx].vd     = vreg_idx_t'(vd);
    stim[idx].vs1    = vreg_idx_t'(vs1);
    stim[idx].vs2    = vreg_idx_t'(vs2);
    stim[idx].scalar = scalar;
    stim[idx].hold   = hold;
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model, element by element over the whole vector
  ////////////////////////////////////////////////////////////

  task automatic apply_to_model(input entry_t ent, output elen_t expected);
    elen_t a;
    elen_t b;
    expected = '0;
    for (int e = 0; e < VecElems; e++) begin
      a = model_vrf[ent.vs1][e];
      b = model_vrf[ent.vs2][e];
      case (ent.op)
        VMV_V_X:  model_vrf[ent.vd][e] = ent.scalar;
        VADD:     model_vrf[ent.vd][e] = b + a;
        VSUB:     model_vrf[ent.vd][e] = b - a;
        VAND:     model_vrf[ent.vd][e] = b & a;
        VXOR:     model_vrf[ent.vd][e] = b ^ a;
        VREDSUM:  expected = expected + b;
        VCPOP_EQ: if (a == b) expected = expected + 1;
        default:  ;
      endcase
    end
  endtask

  // One request, then its response with optional back-pressure
  task automatic issue_and_collect(input entry_t ent, output elen_t result, output int lat);
    elen_t held;
    acc_req_valid_i = 1'b1;
    acc_op_i        = ent.op;
    acc_vd_i        = ent.vd;
    acc_vs1_i       = ent.vs1;
    acc_vs2_i       = ent.vs2;
    acc_scalar_i    = ent.scalar;
    while (!acc_req_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    acc_req_valid_i = 1'b0;
    lat = 0;
    while (!acc_resp_valid_o) begin
      @(negedge clk_i);
      lat++;
    end
    held = acc_resp_result_o;
    repeat (ent.hold) begin
      @(negedge clk_i);
      assert (acc_resp_valid_o && acc_resp_result_o == held && !acc_req_ready_o)
        else stop_with_error("response not held steady under back-pressure");
    end
    result = acc_resp_result_o;
    acc_resp_ready_i = 1'b1;
    @(negedge clk_i);
    acc_resp_ready_i = 1'b0;
  endtask

  initial begin
    elen_t expected;
    elen_t got;
    elen_t s1;
    elen_t s2;
    int    lat;
    reset_i          = 1'b1;
    acc_req_valid_i  = 1'b0;
    acc_op_i         = VMV_V_X;
    acc_vd_i         = '0;
    acc_vs1_i        = '0;
    acc_vs2_i        = '0;
    acc_scalar_i     = '0;
    acc_resp_ready_i = 1'b0;
    for (int r = 0; r < NrVRegs; r++) begin
      for (int e = 0; e < VecElems; e++) model_vrf[r][e] = '0;
    end
    seed = 56506;
    s1 = $random(seed);
    s2 = $random(seed);

    // Index, op, vd, vs1, vs2, scalar, hold
    set_entry(0, VREDSUM, 0, 0, 3, '0, 0);
    set_entry(1, VMV_V_X, 1, 0, 0, s1, 0);
    set_entry(2, VMV_V_X, 2, 0, 0, s2, 0);
    set_entry(3, VADD, 3, 1, 2, '0, 0);
    set_entry(4, VSUB, 4, 1, 2, '0, 0);
    set_entry(5, VAND, 5, 1, 2, '0, 0);
    set_entry(6, VXOR, 6, 1, 2, '0, 3);
    set_entry(7, VREDSUM, 0, 0, 3, '0, 5);
    set_entry(8, VREDSUM, 0, 0, 4, '0, 0);
    set_entry(9, VREDSUM, 0, 0, 5, '0, 0);
    set_entry(10, VREDSUM, 0, 0, 6, '0, 0);
    set_entry(11, VCPOP_EQ, 0, 1, 1, '0, 0);
    set_entry(12, VCPOP_EQ, 0, 1, 2, '0, 4);
    set_entry(13, VMV_V_X, 7, 0, 0, s1, 0);
    set_entry(14, VCPOP_EQ, 0, 1, 7, '0, 0);
    set_entry(15, VADD, 3, 3, 3, '0, 0);
    set_entry(16, VREDSUM, 0, 0, 3, '0, 0);
    set_entry(17, VCPOP_EQ, 0, 0, 7, '0, 0);

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    assert (acc_req_ready_o && !acc_resp_valid_o)
      else stop_with_error("handshake outputs wrong after reset");

    for (int i = 0; i < NumTests; i++) begin
      apply_to_model(stim[i], expected);
      issue_and_collect(stim[i], got, lat);
      assert (lat == ElemsPerLane + 3)
        else stop_with_error($sformatf("entry %0d: response after %0d cycles", i, lat));
      assert (got == expected)
        else stop_with_error($sformatf("entry %0d: result 0x%08h, expected 0x%08h",
                                       i, got, expected));
      assert (req_count == i + 1 && resp_count == i + 1 && !acc_resp_valid_o)
        else stop_with_error($sformatf("entry %0d: %0d requests but %0d responses",
                                       i, req_count, resp_count));
    end

    if (vec_top_i.i_dispatcher.i_asserts.error_count == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("Dispatcher protocol assertions failed %0d times",
               vec_top_i.i_dispatcher.i_asserts.error_count);
      $display("*** FAILED ***");
      $fatal(1, "Protocol check failed");
    end
  end

endmodule : vec_tb

// ==== verilog.f ====
verilog/vec_pkg.sv
verilog/vec_dispatcher.sv
verilog/vec_lane.sv
verilog/vec_reduction.sv
verilog/vec_top.sv
dv/vec_tb_asserts.sv
dv/vec_tb.sv

// ==== Bender.yml ====
package:
  name: vec_coproc

sources:
  # Package first, then the blocks, then the top level
  - verilog/vec_pkg.sv
  - verilog/vec_dispatcher.sv
  - verilog/vec_lane.sv
  - verilog/vec_reduction.sv
  - verilog/vec_top.sv

  - target: simulation
    files:
      - dv/vec_tb_asserts.sv
      - dv/vec_tb.sv
